//--- logic/tile_pkg.sv
package tile_pkg;

	// **************************************************
	// Configuration address, block field (upper 16 bits)
	// **************************************************
	localparam logic [15:0] cfg_block_sb  = 16'd7;
	localparam logic [15:0] cfg_block_cb0 = 16'd6;
	localparam logic [15:0] cfg_block_cb1 = 16'd5;
	localparam logic [15:0] cfg_block_clb = 16'd4;

	localparam int n_tracks = 4;    // Tracks per side

	// Logic block operations
	localparam logic [1:0] op_and  = 2'd0;
	localparam logic [1:0] op_or   = 2'd1;
	localparam logic [1:0] op_xor  = 2'd2;
	localparam logic [1:0] op_nand = 2'd3;

	// One config word, decoded per target block
	typedef union packed {
		struct packed {
			logic [15:0]       rsvd;
			logic [7:0][1:0]   sel;    // [0] is side 0 track 0, [4] is side 1 track 0
		} sb;
		struct packed {
			logic [28:0] rsvd;
			logic [2:0]  sel;
		} cb;
		struct packed {
			logic [29:0] rsvd;
			logic [1:0]  op;
		} clb;
	} cfg_word_u;

endpackage

//--- logic/tile_cfg_if.sv
`timescale 1ns/1ps

interface tile_cfg_if;
	import tile_pkg::*;

	logic      en_sb;
	logic      en_cb0;
	logic      en_cb1;
	logic      en_clb;
	cfg_word_u data;

	// Address decoder side
	modport source (output en_sb, en_cb0, en_cb1, en_clb, data);

	// Configurable blocks
	modport sink (input en_sb, en_cb0, en_cb1, en_clb, data);

endinterface

//--- logic/cfg_decode.sv
`timescale 1ns/1ps

module cfg_decode (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [31:0] config_addr,
	input  logic [15:0] tile_id,
	input  logic [31:0] config_data,
	tile_cfg_if.source  cfg
);
	import tile_pkg::*;

	logic        tile_hit;
	logic [15:0] block;

	assign tile_hit = (config_addr[15:0] == tile_id);
	assign block    = config_addr[31:16];

	// Level decode, no strobe
	assign cfg.en_sb  = tile_hit && (block == cfg_block_sb);
	assign cfg.en_cb0 = tile_hit && (block == cfg_block_cb0);
	assign cfg.en_cb1 = tile_hit && (block == cfg_block_cb1);
	assign cfg.en_clb = tile_hit && (block == cfg_block_clb);

	assign cfg.data = cfg_word_u'(config_data);

	// Never more than one block loading on the same edge
	a_one_block: assert property (
		@(posedge clk) disable iff (!rst_n)
		$onehot0({cfg.en_sb, cfg.en_cb0, cfg.en_cb1, cfg.en_clb})
	);

endmodule

//--- logic/connect_box.sv
`timescale 1ns/1ps

module connect_box (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          en,
	tile_cfg_if.sink                      cfg,
	input  logic [tile_pkg::n_tracks-1:0] side_in,
	input  logic [tile_pkg::n_tracks-1:0] side_out,
	output logic                          operand
);

	// **************************************************
	// Track select register
	// **************************************************
	logic [2:0] sel_q;    // 0..3 side_in, 4..7 side_out

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sel_q <= 3'd0;
		end else if (en) begin
			sel_q <= cfg.data.cb.sel;
		end
	end

	// **************************************************
	// Operand mux
	// **************************************************
	always_comb begin
		if (sel_q[2]) begin
			operand = side_out[sel_q[1:0]];
		end else begin
			operand = side_in[sel_q[1:0]];
		end
	end

	// Select stays defined once out of reset, also across config writes
	a_sel_known: assert property (
		@(posedge clk) disable iff (!rst_n)
		!$isunknown(sel_q)
	);

endmodule

//--- logic/switch_box.sv
`timescale 1ns/1ps

module switch_box (
	input  logic                          clk,
	input  logic                          rst_n,
	tile_cfg_if.sink                      cfg,
	input  logic [tile_pkg::n_tracks-1:0] in_wire_0,
	input  logic [tile_pkg::n_tracks-1:0] in_wire_1,
	input  logic [tile_pkg::n_tracks-1:0] in_wire_2,
	input  logic [tile_pkg::n_tracks-1:0] in_wire_3,
	input  logic                          pe_out,
	output logic [tile_pkg::n_tracks-1:0] out_wire_0,
	output logic [tile_pkg::n_tracks-1:0] out_wire_1
);
	import tile_pkg::*;

	// **************************************************
	// Source selects, one per driven track
	// **************************************************
	logic [2*n_tracks-1:0][1:0] sel_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sel_q <= '0;
		end else if (cfg.en_sb) begin
			sel_q <= cfg.data.sb.sel;
		end
	end

	// Three other sides in ascending order, then the PE result
	function automatic logic pick(
		input logic [1:0] sel,
		input logic       src_a,
		input logic       src_b,
		input logic       src_c,
		input logic       pe
	);
		logic res;
		case (sel)
			2'd0:    res = src_a;
			2'd1:    res = src_b;
			2'd2:    res = src_c;
			default: res = pe;
		endcase
		return res;
	endfunction

	// **************************************************
	// Output muxes, combinational from the inputs
	// **************************************************
	for (genvar t = 0; t < n_tracks; t++) begin : g_track
		// Side 0 takes sides 1, 2, 3
		assign out_wire_0[t] = pick(sel_q[t], in_wire_1[t], in_wire_2[t],
				in_wire_3[t], pe_out);
		// Side 1 takes sides 0, 2, 3
		assign out_wire_1[t] = pick(sel_q[n_tracks+t], in_wire_0[t], in_wire_2[t],
				in_wire_3[t], pe_out);
	end

	// Known sources never produce an X on a routed track
	a_out_known: assert property (
		@(posedge clk) disable iff (!rst_n)
		!$isunknown({in_wire_0, in_wire_1, in_wire_2, in_wire_3, pe_out})
			|-> !$isunknown({out_wire_0, out_wire_1})
	);

endmodule

//--- logic/logic_block.sv
`timescale 1ns/1ps

module logic_block (
	input  logic     clk,
	input  logic     rst_n,
	tile_cfg_if.sink cfg,
	input  logic     in0,
	input  logic     in1,
	output logic     pe_out
);
	import tile_pkg::*;

	logic [1:0] op_q;
	logic       result;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			op_q <= op_and;
		end else if (cfg.en_clb) begin
			op_q <= cfg.data.clb.op;
		end
	end

	always_comb begin
		case (op_q)
			op_and:  result = in0 & in1;
			op_or:   result = in0 | in1;
			op_xor:  result = in0 ^ in1;
			op_nand: result = ~(in0 & in1);
			default: result = 1'b0;
		endcase
	end

	// Registered result, cuts the path back into the switch box
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pe_out <= 1'b0;
		end else begin
			pe_out <= result;
		end
	end

endmodule

//--- logic/pe_tile.sv
`timescale 1ns/1ps

module pe_tile (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic [31:0]                   config_addr,
	input  logic [31:0]                   config_data,
	input  logic [15:0]                   tile_id,
	input  logic [tile_pkg::n_tracks-1:0] in_wire_0,
	input  logic [tile_pkg::n_tracks-1:0] in_wire_1,
	input  logic [tile_pkg::n_tracks-1:0] in_wire_2,
	input  logic [tile_pkg::n_tracks-1:0] in_wire_3,
	output logic [tile_pkg::n_tracks-1:0] out_wire_0,
	output logic [tile_pkg::n_tracks-1:0] out_wire_1
);

	logic op0;
	logic op1;
	logic pe_out;

	tile_cfg_if cfg_if ();

	// **************************************************
	// Config decode
	// **************************************************
	cfg_decode i_decode (
		.clk         (clk),
		.rst_n       (rst_n),
		.config_addr (config_addr),
		.tile_id     (tile_id),
		.config_data (config_data),
		.cfg         (cfg_if.source)
	);

	// **************************************************
	// Routing and compute
	// **************************************************
	switch_box i_sb (
		.clk        (clk),
		.rst_n      (rst_n),
		.cfg        (cfg_if.sink),
		.in_wire_0  (in_wire_0),
		.in_wire_1  (in_wire_1),
		.in_wire_2  (in_wire_2),
		.in_wire_3  (in_wire_3),
		.pe_out     (pe_out),
		.out_wire_0 (out_wire_0),
		.out_wire_1 (out_wire_1)
	);

	connect_box cb0 (
		.clk (clk), .rst_n (rst_n), .en (cfg_if.en_cb0), .cfg (cfg_if.sink),
		.side_in (in_wire_0), .side_out (out_wire_0), .operand (op0)
	);

	connect_box cb1 (
		.clk (clk), .rst_n (rst_n), .en (cfg_if.en_cb1), .cfg (cfg_if.sink),
		.side_in (in_wire_1), .side_out (out_wire_1), .operand (op1)
	);

	logic_block i_clb (
		.clk    (clk),
		.rst_n  (rst_n),
		.cfg    (cfg_if.sink),
		.in0    (op0),
		.in1    (op1),
		.pe_out (pe_out)    // Fed back into the switch box
	);

endmodule

//--- tests/tb_pe_tile.sv
`timescale 1ns/1ps

module tb_pe_tile;
	import tile_pkg::*;

	localparam int max_cycles = 2000;    // Tests use well under half of this

	logic        clk;
	logic        rst_n;
	logic [31:0] config_addr;
	logic [31:0] config_data;
	logic [15:0] tile_id;
	logic [3:0]  in_wire_0;
	logic [3:0]  in_wire_1;
	logic [3:0]  in_wire_2;
	logic [3:0]  in_wire_3;
	logic [3:0]  out_wire_0;
	logic [3:0]  out_wire_1;

	// Reference model of the configuration and the PE register
	logic [1:0] sel_model [8];
	logic [2:0] cb0_model;
	logic [2:0] cb1_model;
	logic [1:0] op_model;
	logic       pe_model;

	integer seed = 32'h5e;
	int     cycle_count = 0;
	int     total_errors = 0;
	int     test_errors = 0;
	int     tests_run = 0;
	int     tests_failed = 0;
	string  test_name;

	pe_tile i_dut (
		.clk         (clk),
		.rst_n       (rst_n),
		.config_addr (config_addr),
		.config_data (config_data),
		.tile_id     (tile_id),
		.in_wire_0   (in_wire_0),
		.in_wire_1   (in_wire_1),
		.in_wire_2   (in_wire_2),
		.in_wire_3   (in_wire_3),
		.out_wire_0  (out_wire_0),
		.out_wire_1  (out_wire_1)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= max_cycles) begin
			$display("timeout: run stopped after %0d cycles", cycle_count);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	// **************************************************
	// Model of the select rules
	// **************************************************
	function automatic logic [3:0] route_side(input int side);
		logic [3:0] res;
		int         t;
		for (t = 0; t < 4; t++) begin
			case (sel_model[4*side + t])
				2'd0:    res[t] = (side == 0) ? in_wire_1[t] : in_wire_0[t];
				2'd1:    res[t] = in_wire_2[t];
				2'd2:    res[t] = in_wire_3[t];
				default: res[t] = pe_model;
			endcase
		end
		return res;
	endfunction

	function automatic logic select_operand(input logic [2:0] sel, input logic [3:0] side_in,
			input logic [3:0] side_out);
		logic [2:0] k;
		if (sel < 3'd4) begin
			return side_in[sel[1:0]];
		end
		k = sel - 3'd4;    // Tracks 4..7 are the driven side
		return side_out[k[1:0]];
	endfunction

	function automatic logic apply_op(input logic [1:0] op, input logic a, input logic b);
		case (op)
			op_and:  return a & b;
			op_or:   return a | b;
			op_xor:  return a ^ b;
			default: return !(a & b);
		endcase
	endfunction

	function automatic logic [15:0] block_code(input logic [1:0] idx);
		case (idx)
			2'd0:    return cfg_block_sb;
			2'd1:    return cfg_block_cb0;
			2'd2:    return cfg_block_cb1;
			default: return cfg_block_clb;
		endcase
	endfunction

	// One clock edge, the model advances with the DUT
	task automatic tick();
		logic        nxt_pe;
		logic        hit;
		logic [15:0] block;
		logic [31:0] data;
		int          i;
		nxt_pe = apply_op(op_model, select_operand(cb0_model, in_wire_0, route_side(0)),
				select_operand(cb1_model, in_wire_1, route_side(1)));
		hit = (config_addr[15:0] == tile_id);
		block = config_addr[31:16];
		data = config_data;
		@(posedge clk);
		#1;
		pe_model = nxt_pe;
		if (hit && block == cfg_block_sb) begin
			for (i = 0; i < 8; i++) begin
				sel_model[i] = data[2*i +: 2];
			end
		end
		if (hit && block == cfg_block_cb0) cb0_model = data[2:0];
		if (hit && block == cfg_block_cb1) cb1_model = data[2:0];
		if (hit && block == cfg_block_clb) op_model = data[1:0];
	endtask

	// **************************************************
	// Stimulus and checks
	// **************************************************
	task automatic write_cfg(input logic [15:0] block, input logic [15:0] id,
			input logic [31:0] data);
		config_addr = {block, id};
		config_data = data;
		tick();
		config_addr = {16'h0000, tile_id};    // Idle
		config_data = 32'h0;
	endtask

	task automatic drive_random();
		logic [31:0] r;
		r = $random(seed);
		in_wire_0 = r[3:0];
		in_wire_1 = r[7:4];
		in_wire_2 = r[11:8];
		in_wire_3 = r[15:12];
		#1;
	endtask

	task automatic check_bits(input string name, input logic [3:0] got, input logic [3:0] want);
		assert (got === want) else begin
			$display("mismatch at %0t: %s expected %h, got %h", $time, name, want, got);
			test_errors++;
			total_errors++;
		end
	endtask

	task automatic check_outputs();
		check_bits("out_wire_0", out_wire_0, route_side(0));
		check_bits("out_wire_1", out_wire_1, route_side(1));
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_errors = 0;
		tests_run++;
	endtask

	task automatic finish_test();
		if (test_errors == 0) begin
			$display("test %s: ok", test_name);
		end else begin
			$display("test %s: %0d errors", test_name, test_errors);
			tests_failed++;
		end
	endtask

	// **************************************************
	// Directed tests
	// **************************************************
	task automatic reset_defaults();
		start_test("reset defaults");
		repeat (20) begin
			drive_random();
			check_bits("out_wire_0", out_wire_0, in_wire_1);
			check_bits("out_wire_1", out_wire_1, in_wire_0);
			tick();
		end
		finish_test();
	endtask

	task automatic switch_routing();
		logic [15:0] words [6];
		int          w;
		words = '{16'h5555, 16'haaaa, 16'hffff, 16'he4e4, 16'h1b6c, 16'h9c3d};
		start_test("switch routing");
		for (w = 0; w < 6; w++) begin
			write_cfg(cfg_block_sb, tile_id, {16'h0000, words[w]});
			repeat (4) begin
				drive_random();
				check_outputs();
				tick();
			end
		end
		finish_test();
	endtask

	task automatic compute_path();
		logic [2:0]  cb0_sels [2];
		logic [2:0]  cb1_sels [2];
		logic [15:0] sb_words [2];
		logic        a;
		logic        b;
		int          p;
		int          o;
		cb0_sels = '{3'd1, 3'd6};
		cb1_sels = '{3'd2, 3'd4};
		sb_words = '{16'hc000, 16'hc210};    // pe on out_wire_1[3] in both
		start_test("connect boxes and logic block");
		for (p = 0; p < 2; p++) begin
			write_cfg(cfg_block_sb, tile_id, {16'h0000, sb_words[p]});
			write_cfg(cfg_block_cb0, tile_id, {29'd0, cb0_sels[p]});
			write_cfg(cfg_block_cb1, tile_id, {29'd0, cb1_sels[p]});
			for (o = 0; o < 4; o++) begin
				write_cfg(cfg_block_clb, tile_id, {30'd0, o[1:0]});
				repeat (6) begin
					drive_random();
					check_outputs();
					a = select_operand(cb0_model, in_wire_0, route_side(0));
					b = select_operand(cb1_model, in_wire_1, route_side(1));
					tick();
					check_bits("out_wire_1[3]", {3'b000, out_wire_1[3]},
							{3'b000, apply_op(o[1:0], a, b)});
				end
			end
		end
		finish_test();
	endtask

	task automatic address_filter();
		logic [31:0] r;
		logic [31:0] data;
		start_test("address filtering");
		write_cfg(cfg_block_sb, tile_id, 32'h0000_e4e4);
		write_cfg(cfg_block_cb0, tile_id, 32'd5);
		write_cfg(cfg_block_cb1, tile_id, 32'd3);
		write_cfg(cfg_block_clb, tile_id, {30'd0, op_xor});
		repeat (10) begin
			r = $random(seed);
			data = $random(seed);
			write_cfg(block_code(r[1:0]), tile_id ^ (r[31:16] | 16'h0001), data);
			write_cfg(16'h0000, tile_id, ~data);    // Block code 0 is the idle address
			drive_random();
			check_outputs();
			tick();
			check_outputs();
		end
		finish_test();
	endtask

	task automatic random_soak();
		logic [31:0] r;
		logic [31:0] data;
		start_test("random soak");
		repeat (200) begin
			r = $random(seed);
			data = $random(seed);
			write_cfg(block_code(r[1:0]), tile_id, data);
			drive_random();
			check_outputs();
			tick();
			check_outputs();
		end
		finish_test();
	endtask

	initial begin
		rst_n = 1'b0;
		config_addr = 32'h0;
		config_data = 32'h0;
		tile_id = 16'h0003;
		in_wire_0 = 4'h0;
		in_wire_1 = 4'h0;
		in_wire_2 = 4'h0;
		in_wire_3 = 4'h0;
		sel_model = '{default: 2'd0};
		cb0_model = 3'd0;
		cb1_model = 3'd0;
		op_model = op_and;
		pe_model = 1'b0;
		repeat (3) @(posedge clk);
		#1;
		rst_n = 1'b1;
		reset_defaults();
		switch_routing();
		compute_path();
		address_filter();
		random_soak();
		$display("tests run %0d, failed %0d, mismatches %0d", tests_run, tests_failed,
				total_errors);
		if (tests_failed == 0 && total_errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

//--- list.f
logic/tile_pkg.sv
logic/tile_cfg_if.sv
logic/cfg_decode.sv
logic/connect_box.sv
logic/switch_box.sv
logic/logic_block.sv
logic/pe_tile.sv
tests/tb_pe_tile.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_pe_tile
RTL_TOP   ?= pe_tile
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= STATUS: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
